// ==== src/env_config.svh ====
//----------------------------------------------------------
// envelope engine configuration
// channel count, field widths, silence level and the
// register field codes of the write port
//----------------------------------------------------------
`ifndef ENV_CONFIG_SVH
`define ENV_CONFIG_SVH

`define ENV_NUM_CHANNELS 4   // operator channels
`define ENV_WIDTH        9   // envelope / attenuation bits
`define ENV_SILENCE      511 // max attenuation
`define ENV_RATE_WIDTH   4   // ar, dr, sl, rr codes
`define ENV_TL_WIDTH     6   // total level
`define ENV_TICK_WIDTH   15  // rate tick counter
`define ENV_ADDR_WIDTH   8
`define ENV_DATA_WIDTH   8
`define ENV_CHAN_WIDTH   2   // addr bits 4:3
`define ENV_FIELD_WIDTH  3   // addr bits 2:0
`define ENV_COUNT_WIDTH  3   // 0..4 active channels

`define ENV_FIELD_AR     3'd0
`define ENV_FIELD_DR     3'd1
`define ENV_FIELD_SL     3'd2
`define ENV_FIELD_RR     3'd3
`define ENV_FIELD_TL     3'd4
`define ENV_FIELD_CTRL   3'd5 // bit 0 egt, bit 1 key

`endif

// ==== src/env_pkg.sv ====
//----------------------------------------------------------
// envelope engine types
// vector typedefs for the meaningful widths and the
// envelope state encoding
//----------------------------------------------------------
`include "env_config.svh"

package env_pkg;

    typedef logic [`ENV_WIDTH-1:0]       env_level_t; // envelope / attenuation
    typedef logic [`ENV_RATE_WIDTH-1:0]  env_rate_t;  // ar, dr, sl, rr
    typedef logic [`ENV_TL_WIDTH-1:0]    env_tl_t;    // total level
    typedef logic [`ENV_CHAN_WIDTH-1:0]  env_chan_t;  // channel index
    typedef logic [`ENV_ADDR_WIDTH-1:0]  env_addr_t;
    typedef logic [`ENV_DATA_WIDTH-1:0]  env_data_t;
    typedef logic [`ENV_TICK_WIDTH-1:0]  env_tick_t;  // sample tick count
    typedef logic [`ENV_COUNT_WIDTH-1:0] env_count_t; // non-silent channels

    // adsr phases
    typedef enum logic [1:0] {
        ENV_ATTACK,
        ENV_DECAY,
        ENV_SUSTAIN,
        ENV_RELEASE
    } env_state_t;

endpackage

// ==== src/env_cfg_if.sv ====
//----------------------------------------------------------
// per-channel configuration interface
// settings and key pulses from the register decoder to
// one channel, total level to the level stage
//----------------------------------------------------------
`timescale 1ns/1ns

interface env_cfg_if
    import env_pkg::*;
();

    env_rate_t ar;      // attack rate
    env_rate_t dr;      // decay rate
    env_rate_t sl;      // sustain level
    env_rate_t rr;      // release rate
    env_tl_t   tl;      // total level, 4 steps per unit
    logic      egt;     // hold in sustain while set
    logic      key_on;  // one-cycle pulse
    logic      key_off; // one-cycle pulse

    modport decoder (output ar, dr, sl, rr, tl, egt, key_on, key_off);
    modport channel (input ar, dr, sl, rr, egt, key_on, key_off);
    modport mixer   (input tl);

endinterface

// ==== src/env_reg_decoder.sv ====
//----------------------------------------------------------
// register write decoder
// stores per-channel settings from byte writes and turns
// key bit edges into one-cycle key_on / key_off pulses
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_reg_decoder
    import env_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              reg_we,
    input  env_addr_t         reg_addr,
    input  env_data_t         reg_data,
    env_cfg_if.decoder        cfg [`ENV_NUM_CHANNELS]
);

    localparam int CHAN_LSB = `ENV_FIELD_WIDTH;
    localparam int HIGH_LSB = `ENV_FIELD_WIDTH + `ENV_CHAN_WIDTH;

    logic [`ENV_FIELD_WIDTH-1:0] field; // register within channel
    env_chan_t                   chan;  // target channel
    logic                        mapped; // upper address bits clear

    assign field  = reg_addr[`ENV_FIELD_WIDTH-1:0];
    assign chan   = reg_addr[CHAN_LSB +: `ENV_CHAN_WIDTH];
    assign mapped = (reg_addr[`ENV_ADDR_WIDTH-1:HIGH_LSB] == '0); // only 0..31 decode

    for (genvar i = 0; i < `ENV_NUM_CHANNELS; i++) begin : g_chan
        logic hit;   // write aimed at this channel
        logic key_q; // last written key bit

        assign hit = reg_we && mapped && (chan == env_chan_t'(i));

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cfg[i].ar      <= '0;
                cfg[i].dr      <= '0;
                cfg[i].sl      <= '0;
                cfg[i].rr      <= '0;
                cfg[i].tl      <= '0;
                cfg[i].egt     <= 1'b0;
                cfg[i].key_on  <= 1'b0;
                cfg[i].key_off <= 1'b0;
                key_q          <= 1'b0;
            end else begin
                cfg[i].key_on  <= 1'b0; // pulses last one cycle
                cfg[i].key_off <= 1'b0;
                if (hit) begin
                    case (field)
                        `ENV_FIELD_AR: cfg[i].ar <= reg_data[`ENV_RATE_WIDTH-1:0];
                        `ENV_FIELD_DR: cfg[i].dr <= reg_data[`ENV_RATE_WIDTH-1:0];
                        `ENV_FIELD_SL: cfg[i].sl <= reg_data[`ENV_RATE_WIDTH-1:0];
                        `ENV_FIELD_RR: cfg[i].rr <= reg_data[`ENV_RATE_WIDTH-1:0];
                        `ENV_FIELD_TL: cfg[i].tl <= reg_data[`ENV_TL_WIDTH-1:0];
                        `ENV_FIELD_CTRL: begin
                            cfg[i].egt     <= reg_data[0];
                            key_q          <= reg_data[1];
                            cfg[i].key_on  <= reg_data[1] && !key_q;  // rising key
                            cfg[i].key_off <= !reg_data[1] && key_q;  // falling key
                        end
                        default: ; // codes 6, 7 unmapped
                    endcase
                end
            end
        end
    end

endmodule

// ==== src/env_rate_counter.sv ====
//----------------------------------------------------------
// envelope rate counter
// counts sample ticks and flags a step when the low
// (15 - rate) bits of the new count are all zero
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_rate_counter
    import env_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sample_en, // one-cycle sample strobe
    input  logic      clear,     // key-on restarts the count
    input  env_rate_t rate,      // rate in force, 0 stops stepping
    output logic      step       // envelope step due this tick
);

    env_tick_t tick;      // ticks since key-on
    env_tick_t tick_next; // count after this tick
    env_tick_t mask;      // low (15 - rate) bits

    assign tick_next = tick + env_tick_t'(1);
    assign mask      = {`ENV_TICK_WIDTH{1'b1}} >> rate; // rate 15 masks nothing

    // higher rate -> fewer bits to roll over -> more frequent steps
    assign step = sample_en && !clear && (rate != '0) && ((tick_next & mask) == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick <= '0;
        end else if (clear) begin
            tick <= '0; // clear beats the tick
        end else if (sample_en) begin
            tick <= tick_next; // wraps at 2^15
        end
    end

endmodule

// ==== src/env_channel.sv ====
//----------------------------------------------------------
// envelope channel
// adsr state machine and 9-bit level register, stepped
// by the rate counter on sample ticks
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_channel
    import env_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_en, // sample strobe
    env_cfg_if.channel cfg,       // settings and key pulses
    output env_level_t level      // current envelope, 511 = silent
);

    env_state_t state;       // current phase
    env_state_t next_state;  // phase after this tick
    env_rate_t  rate;        // rate in force
    logic       step;        // level update due
    env_level_t attack_dec;  // attack decrement
    env_level_t level_step;  // level after one step
    logic       key_pulse;   // either key event

    assign key_pulse = cfg.key_on || cfg.key_off;

    env_rate_counter env_rate_counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_en (sample_en),
        .clear     (cfg.key_on),
        .rate      (rate),
        .step      (step)
    );

    // rate per phase, sustain never steps
    always_comb begin
        case (state)
            ENV_ATTACK:  rate = cfg.ar;
            ENV_DECAY:   rate = cfg.dr;
            ENV_SUSTAIN: rate = '0;
            default:     rate = cfg.rr;
        endcase
    end

    // transitions judged on the level before the step
    always_comb begin
        next_state = state;
        case (state)
            ENV_ATTACK: begin
                if (level == '0)
                    next_state = ENV_DECAY; // full volume reached
            end
            ENV_DECAY: begin
                if ((level >> 4) >= env_level_t'(cfg.sl))
                    next_state = ENV_SUSTAIN; // sl in units of 16
            end
            ENV_SUSTAIN: begin
                if (!cfg.egt)
                    next_state = ENV_RELEASE; // no hold, fall through
            end
            default: ; // release held until key-on
        endcase
    end

    assign attack_dec = (level >> 3) + env_level_t'(1); // exponential approach to 0

    always_comb begin
        level_step = level;
        if (state == ENV_ATTACK) begin
            if (attack_dec >= level)
                level_step = '0; // floor at full volume
            else
                level_step = level - attack_dec;
        end else if (level != env_level_t'(`ENV_SILENCE)) begin
            level_step = level + env_level_t'(1); // decay, release: linear
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ENV_RELEASE;
            level <= env_level_t'(`ENV_SILENCE); // start silent
        end else if (key_pulse) begin
            // key event wins over the tick, level kept
            state <= cfg.key_on ? ENV_ATTACK : ENV_RELEASE;
        end else if (sample_en) begin
            state <= next_state;
            if (step)
                level <= level_step;
        end
    end

endmodule

// ==== src/env_level_mixer.sv ====
//----------------------------------------------------------
// level stage
// adds 4 x total level to each envelope, clamps at
// silence, registers the selected channel and the count
// of channels that are not silent
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_level_mixer
    import env_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    env_cfg_if.mixer    cfg [`ENV_NUM_CHANNELS],     // total level per channel
    input  env_level_t  levels [`ENV_NUM_CHANNELS],  // raw envelopes
    input  env_chan_t   atten_sel,                   // read channel
    output env_level_t  atten,                       // selected attenuation
    output env_count_t  active_count                 // levels below silence
);

    env_level_t clamped [`ENV_NUM_CHANNELS]; // per-channel attenuation
    env_count_t active_next;                 // combinational count

    for (genvar i = 0; i < `ENV_NUM_CHANNELS; i++) begin : g_sum
        logic [`ENV_WIDTH:0] sum; // one spare bit, max 511 + 252

        assign sum = {1'b0, levels[i]} + ((`ENV_WIDTH+1)'(cfg[i].tl) << 2);

        assign clamped[i] = (sum > (`ENV_WIDTH+1)'(`ENV_SILENCE))
                          ? env_level_t'(`ENV_SILENCE)
                          : sum[`ENV_WIDTH-1:0];
    end

    // raw level decides activity, tl does not
    always_comb begin
        active_next = '0;
        for (int i = 0; i < `ENV_NUM_CHANNELS; i++) begin
            if (levels[i] != env_level_t'(`ENV_SILENCE))
                active_next = active_next + env_count_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            atten        <= env_level_t'(`ENV_SILENCE);
            active_count <= '0;
        end else begin
            atten        <= clamped[atten_sel]; // one cycle behind levels
            active_count <= active_next;
        end
    end

endmodule

// ==== src/env_top.sv ====
//----------------------------------------------------------
// envelope engine top level
// register decoder, four adsr channels and the level
// stage, joined by per-channel config interfaces
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_top
    import env_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sample_en,    // one-cycle sample strobe
    input  logic       reg_we,       // register write strobe
    input  env_addr_t  reg_addr,     // {chan, field}
    input  env_data_t  reg_data,
    input  env_chan_t  atten_sel,    // channel to read
    output env_level_t atten,        // registered attenuation
    output env_count_t active_count  // non-silent channels
);

    env_cfg_if  cfg [`ENV_NUM_CHANNELS] ();  // one per channel
    env_level_t levels [`ENV_NUM_CHANNELS];  // channel envelopes

    env_reg_decoder env_reg_decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .reg_we   (reg_we),
        .reg_addr (reg_addr),
        .reg_data (reg_data),
        .cfg      (cfg)
    );

    for (genvar i = 0; i < `ENV_NUM_CHANNELS; i++) begin : g_chan
        env_channel env_channel_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .sample_en (sample_en),
            .cfg       (cfg[i]),
            .level     (levels[i])
        );
    end

    env_level_mixer env_level_mixer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg          (cfg),
        .levels       (levels),
        .atten_sel    (atten_sel),
        .atten        (atten),
        .active_count (active_count)
    );

endmodule

// ==== tb/env_assertions.sv ====
//----------------------------------------------------------
// envelope engine assertions
// level held between ticks, silent output with no active
// channel and active count range, bound into the top level
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_assertions
    import env_pkg::*;
(
    input logic                         clk,
    input logic                         rst_n,
    input logic                         sample_en,
    input env_level_t                   levels [`ENV_NUM_CHANNELS],
    input logic [`ENV_NUM_CHANNELS-1:0] key_on,  // one bit per channel
    input logic [`ENV_NUM_CHANNELS-1:0] key_off,
    input env_level_t                   atten,
    input env_count_t                   active_count
);

    // level moves only on a tick without a key event
    for (genvar i = 0; i < `ENV_NUM_CHANNELS; i++) begin : g_chan
        level_held: assert property (@(posedge clk) disable iff (!rst_n)
            (!sample_en || key_on[i] || key_off[i]) |=> $stable(levels[i]))
            else $error("channel %0d level changed without a sample tick", i);
    end

    silent_atten: assert property (@(posedge clk) disable iff (!rst_n)
        (active_count == '0) |-> (atten == env_level_t'(`ENV_SILENCE)))
        else $error("atten below silence while no channel is active");

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        active_count <= env_count_t'(`ENV_NUM_CHANNELS))
        else $error("active_count above channel count");

endmodule

bind env_top env_assertions env_assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_en    (sample_en),
    .levels       (levels),
    .key_on       ({cfg[3].key_on, cfg[2].key_on, cfg[1].key_on, cfg[0].key_on}),
    .key_off      ({cfg[3].key_off, cfg[2].key_off, cfg[1].key_off, cfg[0].key_off}),
    .atten        (atten),
    .active_count (active_count)
);

// ==== tb/env_tb.sv ====
//----------------------------------------------------------
// envelope engine testbench
// directed adsr runs, tl clamp and random register
// traffic, compared each cycle with a channel model
//----------------------------------------------------------
`timescale 1ns/1ns
`include "env_config.svh"

module env_tb
    import env_pkg::*;
();

    localparam int N     = `ENV_NUM_CHANNELS;
    localparam int P1    = 2 * N;                       // reset values, each atten_sel
    localparam int P2    = 6 + 600;                     // attack, decay into sustain
    localparam int P3    = 100 + 1 + 2000;              // sustain hold, release
    localparam int P4    = 6 + 500 + 1 + 20 + 1 + 1900; // tl offset and clamp
    localparam int P5    = 2000;                        // random traffic
    localparam int P6    = 2 * N + 20;                  // unmapped fields
    localparam int LIMIT = 4 + P1 + P2 + P3 + P4 + P5 + P6 + 200;

    logic       clk;
    logic       rst_n;
    logic       sample_en;
    logic       reg_we;
    env_addr_t  reg_addr;
    env_data_t  reg_data;
    env_chan_t  atten_sel;
    env_level_t atten;
    env_count_t active_count;

    // model copies of every dut register
    env_rate_t  m_ar [N];
    env_rate_t  m_dr [N];
    env_rate_t  m_sl [N];
    env_rate_t  m_rr [N];
    env_tl_t    m_tl [N];
    logic       m_egt [N];
    logic       m_key [N];
    logic       m_on [N];
    logic       m_off [N];
    env_tick_t  m_tick [N];
    env_state_t m_state [N];
    env_level_t m_level [N];
    env_level_t m_atten;
    env_count_t m_active;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          phase  = 0;    // position in the 4-cycle sample period
    bit          random_sel = 0;
    logic [31:0] rng = 32'hd3ac_49e5;

    env_top env_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < N; i++) begin
            {m_ar[i], m_dr[i], m_sl[i], m_rr[i], m_tl[i]} = '0;
            {m_egt[i], m_key[i], m_on[i], m_off[i]} = '0;
            m_tick[i]  = '0;
            m_state[i] = ENV_RELEASE;
            m_level[i] = env_level_t'(`ENV_SILENCE);
        end
        m_atten  = env_level_t'(`ENV_SILENCE);
        m_active = '0;
    endfunction

    // one clock edge of the whole engine, old values feed every next value
    function automatic void env_model_step(input logic we, input env_addr_t addr,
                                           input env_data_t data, input logic smp,
                                           input env_chan_t sel);
        int         sum;
        int         cnt;
        int         lvl;
        int         r;
        env_state_t st;
        env_chan_t  ch;
        sum = int'(m_level[sel]) + 4 * int'(m_tl[sel]);
        m_atten = (sum > `ENV_SILENCE) ? env_level_t'(`ENV_SILENCE) : env_level_t'(sum);
        cnt = 0;
        for (int i = 0; i < N; i++) begin
            if (int'(m_level[i]) < `ENV_SILENCE)
                cnt++;
        end
        m_active = env_count_t'(cnt);
        for (int i = 0; i < N; i++) begin
            if (m_on[i] || m_off[i]) begin
                if (m_on[i])
                    m_tick[i] = '0;                      // restart on key-on
                else if (smp)
                    m_tick[i] = m_tick[i] + env_tick_t'(1); // key-off keeps counting
                m_state[i] = m_on[i] ? ENV_ATTACK : ENV_RELEASE;
            end else if (smp) begin
                r = (m_state[i] == ENV_ATTACK) ? int'(m_ar[i]) :
                    (m_state[i] == ENV_DECAY)  ? int'(m_dr[i]) :
                    (m_state[i] == ENV_RELEASE) ? int'(m_rr[i]) : 0;
                m_tick[i] = m_tick[i] + env_tick_t'(1);
                lvl = int'(m_level[i]);
                if (r != 0 && int'(m_tick[i]) % (1 << (`ENV_TICK_WIDTH - r)) == 0) begin
                    if (m_state[i] == ENV_ATTACK)
                        lvl = (lvl - (lvl / 8 + 1) < 0) ? 0 : lvl - (lvl / 8 + 1);
                    else
                        lvl = (lvl + 1 > `ENV_SILENCE) ? `ENV_SILENCE : lvl + 1;
                end
                st = m_state[i];
                if (st == ENV_ATTACK && m_level[i] == '0)
                    st = ENV_DECAY;
                else if (st == ENV_DECAY && int'(m_level[i]) / 16 >= int'(m_sl[i]))
                    st = ENV_SUSTAIN;
                else if (st == ENV_SUSTAIN && !m_egt[i])
                    st = ENV_RELEASE;
                m_state[i] = st;
                m_level[i] = env_level_t'(lvl);
            end
            m_on[i]  = 1'b0;
            m_off[i] = 1'b0;
        end
        if (we && addr[7:5] == 3'b000) begin
            ch = addr[4:3];
            case (addr[2:0])
                `ENV_FIELD_AR: m_ar[ch] = data[3:0];
                `ENV_FIELD_DR: m_dr[ch] = data[3:0];
                `ENV_FIELD_SL: m_sl[ch] = data[3:0];
                `ENV_FIELD_RR: m_rr[ch] = data[3:0];
                `ENV_FIELD_TL: m_tl[ch] = data[5:0];
                `ENV_FIELD_CTRL: begin
                    m_egt[ch] = data[0];
                    m_on[ch]  = data[1] && !m_key[ch];
                    m_off[ch] = !data[1] && m_key[ch];
                    m_key[ch] = data[1];
                end
                default: ;
            endcase
        end
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    // outputs settled since the rising edge, inputs held until the next one
    always @(negedge clk) begin
        if (!rst_n) begin
            model_reset();
        end else begin
            check_value(32'(atten), 32'(m_atten), "atten");
            check_value(32'(active_count), 32'(m_active), "active_count");
            env_model_step(reg_we, reg_addr, reg_data, sample_en, atten_sel);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: stimulus still running after %0d cycles", LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
        reg_we    = 1'b0;
        sample_en = (phase == 3); // every 4th cycle
        phase     = (phase + 1) % 4;
        if (random_sel) begin
            rng       = xorshift32(rng);
            atten_sel = rng[1:0];
        end
    endtask

    task automatic write_reg(input int ch, input int field, input int data);
        next_cycle();
        reg_we   = 1'b1;
        reg_addr = {3'b000, 2'(ch), 3'(field)};
        reg_data = 8'(data);
    endtask

    initial begin
        {rst_n, sample_en, reg_we, reg_addr, reg_data, atten_sel} = '0;
        repeat (4) @(posedge clk);
        #5 rst_n = 1'b1;
        for (int s = 0; s < N; s++) begin
            next_cycle();
            atten_sel = env_chan_t'(s);
            next_cycle();
            check_value(32'(atten), `ENV_SILENCE, "atten after reset");
            check_value(32'(active_count), 0, "active_count after reset");
        end
        atten_sel = '0;
        write_reg(0, `ENV_FIELD_AR, 14);
        write_reg(0, `ENV_FIELD_DR, 15);
        write_reg(0, `ENV_FIELD_SL, 3);
        write_reg(0, `ENV_FIELD_RR, 15);
        write_reg(0, `ENV_FIELD_TL, 0);
        write_reg(0, `ENV_FIELD_CTRL, 3);    // key on, egt set
        repeat (600) next_cycle();
        check_value(32'(active_count), 1, "active_count in sustain");
        repeat (100) next_cycle();           // egt holds sustain
        write_reg(0, `ENV_FIELD_CTRL, 2);    // egt clear, key stays
        repeat (2000) next_cycle();
        check_value(32'(active_count), 0, "active_count after release");
        atten_sel = 2'd1;
        write_reg(1, `ENV_FIELD_AR, 15);
        write_reg(1, `ENV_FIELD_DR, 15);
        write_reg(1, `ENV_FIELD_SL, 4);
        write_reg(1, `ENV_FIELD_RR, 15);
        write_reg(1, `ENV_FIELD_TL, 40);
        write_reg(1, `ENV_FIELD_CTRL, 3);
        repeat (500) next_cycle();
        write_reg(1, `ENV_FIELD_TL, 63);     // clamps once release passes 259
        repeat (20) next_cycle();
        write_reg(1, `ENV_FIELD_CTRL, 0);    // key off
        repeat (1900) next_cycle();
        random_sel = 1'b1;
        repeat (P5) begin
            next_cycle();
            rng = xorshift32(rng);
            if (rng[3:2] == 2'b00) begin
                reg_we   = 1'b1;
                reg_addr = rng[20] ? rng[31:24] : {3'b000, rng[12:8]};
                reg_data = rng[23:16];
            end
        end
        // atten_sel keeps moving so every channel's tl stays visible
        for (int c = 0; c < N; c++) begin
            write_reg(c, 6, 8'hff);
            write_reg(c, 7, 8'hff);
        end
        repeat (20) next_cycle();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/env_pkg.sv
src/env_cfg_if.sv
src/env_reg_decoder.sv
src/env_rate_counter.sv
src/env_channel.sv
src/env_level_mixer.sv
src/env_top.sv
tb/env_assertions.sv
tb/env_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the envelope engine testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
    --top-module env_tb -o env_sim \
    && ./obj_dir/env_sim > sim.log 2>&1 \
    || echo "Finished with errors" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && echo "FAIL" && exit 1
echo "PASS"
exit 0
